// File: verilog/dcache_defines.svh
// cache geometry and port counts, included by the package and the testbench
`ifndef DCACHE_DEFINES_SVH
`define DCACHE_DEFINES_SVH

////////////////////////////////
// ports
////////////////////////////////

// read ports sharing the lookup path
`define DCACHE_NUM_PORTS 3

////////////////////////////////
// geometry
////////////////////////////////

// ways per set
`define DCACHE_SET_ASSOC 2

// lines per way
`define DCACHE_NUM_SETS 16

`define DCACHE_WORD_W 32

// words per line, each word offset lives in its own bank
`define DCACHE_NUM_BANKS 4

`define DCACHE_TAG_W 8

// byte offset in a line, upper two bits pick the bank
`define DCACHE_OFF_W 4

`endif

// File: verilog/dcache_pkg.sv
// shared types of the cache memory block, imported by every RTL module
`include "dcache_defines.svh"

package dcache_pkg;

  // address fields
  typedef logic [$clog2(`DCACHE_NUM_SETS)-1:0]  idx_t;
  typedef logic [`DCACHE_OFF_W-1:0]             off_t;
  typedef logic [$clog2(`DCACHE_NUM_BANKS)-1:0] bank_sel_t;
  typedef logic [`DCACHE_TAG_W-1:0]             tag_t;

  // per-way and per-port vectors
  typedef logic [`DCACHE_SET_ASSOC-1:0]         way_vec_t;
  typedef logic [`DCACHE_NUM_PORTS-1:0]         port_vec_t;
  typedef logic [$clog2(`DCACHE_NUM_PORTS)-1:0] port_sel_t;

  // data payloads
  typedef logic [`DCACHE_WORD_W-1:0]   word_t;
  typedef logic [`DCACHE_WORD_W/8-1:0] word_be_t;

  // one bank row, way 0 in the low bits
  typedef word_t [`DCACHE_SET_ASSOC-1:0] bank_word_t;

  typedef struct packed {
    logic valid;
    tag_t tag;
  } tag_entry_t;

  // refill line, bank 0 in the low bits
  typedef word_t    [`DCACHE_NUM_BANKS-1:0] line_t;
  typedef word_be_t [`DCACHE_NUM_BANKS-1:0] line_be_t;

endpackage

// File: verilog/dcache_sram.sv
// single-port synchronous RAM with a bit write mask, holds any packed payload type
`timescale 1ns/1ps

module dcache_sram #(
  parameter type         word_type = logic,
  parameter int unsigned NUM_WORDS = 256
) (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  logic                         req_i,
  input  logic                         we_i,
  input  logic [$clog2(NUM_WORDS)-1:0] addr_i,
  input  word_type                     wdata_i,
  input  word_type                     wmask_i,
  output word_type                     rdata_o
);

  word_type mem_q [NUM_WORDS];
  word_type merged;

  // keep unmasked bits of the stored word
  assign merged = word_type'((mem_q[addr_i] & ~wmask_i) | (wdata_i & wmask_i));

  ////////////////////////////////
  // storage
  ////////////////////////////////

  always_ff @(posedge clk_i) begin : p_write
    if (req_i && we_i) begin
      mem_q[addr_i] <= merged;
    end
  end

  ////////////////////////////////
  // read port
  ////////////////////////////////

  // output holds its last word while the RAM is idle or written
  always_ff @(posedge clk_i or negedge rst_ni) begin : p_read
    if (!rst_ni) begin
      rdata_o <= '0;
    end else if (req_i && !we_i) begin
      rdata_o <= mem_q[addr_i];
    end
  end

endmodule

// File: verilog/dcache_bank_arbiter.sv
// read-port arbitration and bank/tag RAM control, the request side of the cache memory
`timescale 1ns/1ps
`include "dcache_defines.svh"

module dcache_bank_arbiter import dcache_pkg::*; (
  input  logic                                   clk_i,
  input  logic                                   rst_ni,
  // read ports
  input  port_vec_t                              rd_req_i,
  input  port_vec_t                              rd_prio_i,
  input  idx_t [`DCACHE_NUM_PORTS-1:0]           rd_idx_i,
  input  off_t [`DCACHE_NUM_PORTS-1:0]           rd_off_i,
  output port_vec_t                              rd_ack_o,
  output port_sel_t                              rd_sel_o,
  output logic                                   rd_go_o,
  // refill and word write
  input  logic                                   wr_cl_vld_i,
  input  way_vec_t                               wr_cl_we_i,
  input  idx_t                                   wr_cl_idx_i,
  input  way_vec_t                               wr_req_i,
  input  idx_t                                   wr_idx_i,
  input  off_t                                   wr_off_i,
  output logic                                   wr_ack_o,
  // RAM control
  output logic [`DCACHE_NUM_BANKS-1:0]           bank_req_o,
  output logic [`DCACHE_NUM_BANKS-1:0]           bank_we_o,
  output idx_t [`DCACHE_NUM_BANKS-1:0]           bank_idx_o,
  output way_vec_t                               tag_req_o,
  output logic                                   tag_we_o,
  output idx_t                                   tag_idx_o
);

  localparam int unsigned BANK_LSB = `DCACHE_OFF_W - $bits(bank_sel_t);

  port_vec_t rd_req_prio;
  port_vec_t rd_req_masked;
  port_sel_t rr_q;
  port_sel_t rr_next;
  port_sel_t rd_sel;
  logic      rd_found;
  logic      rd_go;
  bank_sel_t rd_bank;
  bank_sel_t wr_bank;
  logic      collision;

  ////////////////////////////////
  // read arbitration
  ////////////////////////////////

  // high priority requesters shut out the low ones
  assign rd_req_prio   = rd_req_i & rd_prio_i;
  assign rd_req_masked = (|rd_req_prio) ? rd_req_prio : rd_req_i;

  // first masked requester at or after the pointer, wrapping
  always_comb begin : p_rr_pick
    int unsigned cand;
    rd_found = 1'b0;
    rd_sel   = '0;
    for (int unsigned i = 0; i < `DCACHE_NUM_PORTS; i++) begin
      cand = (rr_q + i) % `DCACHE_NUM_PORTS;
      if (!rd_found && rd_req_masked[cand]) begin
        rd_found = 1'b1;
        rd_sel   = port_sel_t'(cand);
      end
    end
  end

  // a refill owns every RAM this cycle
  assign rd_go   = rd_found & ~wr_cl_vld_i;
  assign rr_next = (rd_sel == port_sel_t'(`DCACHE_NUM_PORTS - 1)) ? '0 : rd_sel + 1'b1;

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_rr_ptr
    if (!rst_ni) begin
      rr_q <= '0;
    end else if (rd_go) begin
      rr_q <= rr_next;
    end
  end

  always_comb begin : p_ack
    rd_ack_o = '0;
    if (rd_go) begin
      rd_ack_o[rd_sel] = 1'b1;
    end
  end

  assign rd_sel_o = rd_sel;
  assign rd_go_o  = rd_go;

  ////////////////////////////////
  // bank control
  ////////////////////////////////

  assign rd_bank   = rd_off_i[rd_sel][`DCACHE_OFF_W-1:BANK_LSB];
  assign wr_bank   = wr_off_i[`DCACHE_OFF_W-1:BANK_LSB];
  // word write only stalls on a bank taken by the granted read
  assign collision = rd_go && (rd_bank == wr_bank);
  assign wr_ack_o  = (|wr_req_i) && !wr_cl_vld_i && !collision;

  always_comb begin : p_bank
    bank_req_o = '0;
    bank_we_o  = '0;
    for (int k = 0; k < `DCACHE_NUM_BANKS; k++) begin
      bank_idx_o[k] = wr_cl_vld_i ? wr_cl_idx_i : wr_idx_i;
    end
    if (wr_cl_vld_i) begin
      bank_req_o = '1;
      bank_we_o  = '1;
    end else begin
      if (rd_go) begin
        bank_req_o[rd_bank] = 1'b1;
        bank_idx_o[rd_bank] = rd_idx_i[rd_sel];
      end
      if (wr_ack_o) begin
        bank_req_o[wr_bank] = 1'b1;
        bank_we_o[wr_bank]  = 1'b1;
      end
    end
  end

  // tags are read in every way on a grant, written per way on a refill
  assign tag_we_o  = wr_cl_vld_i;
  assign tag_idx_o = wr_cl_vld_i ? wr_cl_idx_i : rd_idx_i[rd_sel];
  assign tag_req_o = wr_cl_vld_i ? wr_cl_we_i : {`DCACHE_SET_ASSOC{rd_go}};

endmodule

// File: verilog/dcache_arrays.sv
// data banks and tag RAMs of the cache, with write data and bit masks per way
`timescale 1ns/1ps
`include "dcache_defines.svh"

module dcache_arrays import dcache_pkg::*; (
  input  logic                                   clk_i,
  input  logic                                   rst_ni,
  input  logic [`DCACHE_NUM_BANKS-1:0]           bank_req_i,
  input  logic [`DCACHE_NUM_BANKS-1:0]           bank_we_i,
  input  idx_t [`DCACHE_NUM_BANKS-1:0]           bank_idx_i,
  input  way_vec_t                               tag_req_i,
  input  logic                                   tag_we_i,
  input  idx_t                                   tag_idx_i,
  input  logic                                   wr_cl_vld_i,
  input  way_vec_t                               wr_cl_we_i,
  input  line_t                                  wr_cl_data_i,
  input  line_be_t                               wr_cl_data_be_i,
  input  tag_t                                   wr_cl_tag_i,
  input  way_vec_t                               wr_vld_bits_i,
  input  way_vec_t                               wr_req_i,
  input  word_t                                  wr_data_i,
  input  word_be_t                               wr_data_be_i,
  output bank_word_t [`DCACHE_NUM_BANKS-1:0]     bank_rdata_o,
  output tag_entry_t [`DCACHE_SET_ASSOC-1:0]     tag_rdata_o
);

  bank_word_t [`DCACHE_NUM_BANKS-1:0] bank_wdata;
  bank_word_t [`DCACHE_NUM_BANKS-1:0] bank_wmask;

  // byte enables to a bit mask
  function automatic word_t be_to_mask(word_be_t be);
    word_t mask;
    for (int b = 0; b < $bits(word_be_t); b++) begin
      mask[8*b +: 8] = {8{be[b]}};
    end
    return mask;
  endfunction

  // refill writes the line slice, a word write only its own way
  always_comb begin : p_wmask
    bank_wdata = '0;
    bank_wmask = '0;
    for (int k = 0; k < `DCACHE_NUM_BANKS; k++) begin
      for (int w = 0; w < `DCACHE_SET_ASSOC; w++) begin
        if (wr_cl_vld_i && wr_cl_we_i[w]) begin
          bank_wdata[k][w] = wr_cl_data_i[k];
          bank_wmask[k][w] = be_to_mask(wr_cl_data_be_i[k]);
        end else if (!wr_cl_vld_i && bank_we_i[k] && wr_req_i[w]) begin
          bank_wdata[k][w] = wr_data_i;
          bank_wmask[k][w] = be_to_mask(wr_data_be_i);
        end
      end
    end
  end

  ////////////////////////////////
  // RAM instances
  ////////////////////////////////

  for (genvar k = 0; k < `DCACHE_NUM_BANKS; k++) begin : gen_data_bank
    dcache_sram #(
      .word_type (bank_word_t),
      .NUM_WORDS (`DCACHE_NUM_SETS)
    ) u_data_sram (
      .clk_i   (clk_i),
      .rst_ni  (rst_ni),
      .req_i   (bank_req_i[k]),
      .we_i    (bank_we_i[k]),
      .addr_i  (bank_idx_i[k]),
      .wdata_i (bank_wdata[k]),
      .wmask_i (bank_wmask[k]),
      .rdata_o (bank_rdata_o[k])
    );
  end

  for (genvar w = 0; w < `DCACHE_SET_ASSOC; w++) begin : gen_tag_way
    tag_entry_t tag_wdata;

    assign tag_wdata = '{valid: wr_vld_bits_i[w], tag: wr_cl_tag_i};

    dcache_sram #(
      .word_type (tag_entry_t),
      .NUM_WORDS (`DCACHE_NUM_SETS)
    ) u_tag_sram (
      .clk_i   (clk_i),
      .rst_ni  (rst_ni),
      .req_i   (tag_req_i[w]),
      .we_i    (tag_we_i),
      .addr_i  (tag_idx_i),
      .wdata_i (tag_wdata),
      .wmask_i (tag_entry_t'('1)),
      .rdata_o (tag_rdata_o[w])
    );
  end

endmodule

// File: verilog/dcache_hit_select.sv
// tag compare and way select, turns the RAM outputs into the read result one cycle after a grant
`timescale 1ns/1ps
`include "dcache_defines.svh"

module dcache_hit_select import dcache_pkg::*; (
  input  logic                                   clk_i,
  input  logic                                   rst_ni,
  input  logic                                   rd_go_i,
  input  port_sel_t                              rd_sel_i,
  input  off_t [`DCACHE_NUM_PORTS-1:0]           rd_off_i,
  // tag arrives one cycle after the grant
  input  tag_t [`DCACHE_NUM_PORTS-1:0]           rd_tag_i,
  input  bank_word_t [`DCACHE_NUM_BANKS-1:0]     bank_rdata_i,
  input  tag_entry_t [`DCACHE_SET_ASSOC-1:0]     tag_rdata_i,
  output way_vec_t                               rd_vld_bits_o,
  output way_vec_t                               rd_hit_oh_o,
  output word_t                                  rd_data_o
);

  localparam int unsigned BANK_LSB = `DCACHE_OFF_W - $bits(bank_sel_t);

  logic      go_q;
  port_sel_t sel_q;
  bank_sel_t bank_q;
  tag_t      rd_tag;
  way_vec_t  hit;

  ////////////////////////////////
  // lookup context
  ////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_ctx
    if (!rst_ni) begin
      go_q   <= 1'b0;
      sel_q  <= '0;
      bank_q <= '0;
    end else begin
      go_q   <= rd_go_i;
      sel_q  <= rd_sel_i;
      bank_q <= rd_off_i[rd_sel_i][`DCACHE_OFF_W-1:BANK_LSB];
    end
  end

  assign rd_tag = rd_tag_i[sel_q];

  for (genvar w = 0; w < `DCACHE_SET_ASSOC; w++) begin : gen_cmp
    assign rd_vld_bits_o[w] = tag_rdata_i[w].valid;
    assign hit[w] = go_q && tag_rdata_i[w].valid && (tag_rdata_i[w].tag == rd_tag);
  end

  assign rd_hit_oh_o = hit;

  // lowest hitting way wins, way 0 on a miss
  always_comb begin : p_way_mux
    rd_data_o = bank_rdata_i[bank_q][0];
    for (int w = `DCACHE_SET_ASSOC - 1; w >= 0; w--) begin
      if (hit[w]) begin
        rd_data_o = bank_rdata_i[bank_q][w];
      end
    end
  end

endmodule

// File: verilog/dcache_mem.sv
// top of the cache memory block, ties the arbiter, RAM arrays and hit selector together
`timescale 1ns/1ps
`include "dcache_defines.svh"

module dcache_mem import dcache_pkg::*; (
  input  logic                                   clk_i,
  input  logic                                   rst_ni,
  // read ports
  input  port_vec_t                              rd_req_i,
  input  port_vec_t                              rd_prio_i,
  input  idx_t [`DCACHE_NUM_PORTS-1:0]           rd_idx_i,
  input  off_t [`DCACHE_NUM_PORTS-1:0]           rd_off_i,
  input  tag_t [`DCACHE_NUM_PORTS-1:0]           rd_tag_i,
  output port_vec_t                              rd_ack_o,
  output way_vec_t                               rd_vld_bits_o,
  output way_vec_t                               rd_hit_oh_o,
  output word_t                                  rd_data_o,
  // refill
  input  logic                                   wr_cl_vld_i,
  input  way_vec_t                               wr_cl_we_i,
  input  idx_t                                   wr_cl_idx_i,
  input  tag_t                                   wr_cl_tag_i,
  input  line_t                                  wr_cl_data_i,
  input  line_be_t                               wr_cl_data_be_i,
  input  way_vec_t                               wr_vld_bits_i,
  // word write
  input  way_vec_t                               wr_req_i,
  input  idx_t                                   wr_idx_i,
  input  off_t                                   wr_off_i,
  input  word_t                                  wr_data_i,
  input  word_be_t                               wr_data_be_i,
  output logic                                   wr_ack_o
);

  port_sel_t                          rd_sel;
  logic                               rd_go;
  logic [`DCACHE_NUM_BANKS-1:0]       bank_req;
  logic [`DCACHE_NUM_BANKS-1:0]       bank_we;
  idx_t [`DCACHE_NUM_BANKS-1:0]       bank_idx;
  way_vec_t                           tag_req;
  logic                               tag_we;
  idx_t                               tag_idx;
  bank_word_t [`DCACHE_NUM_BANKS-1:0] bank_rdata;
  tag_entry_t [`DCACHE_SET_ASSOC-1:0] tag_rdata;

  dcache_bank_arbiter u_arbiter (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .rd_req_i    (rd_req_i),
    .rd_prio_i   (rd_prio_i),
    .rd_idx_i    (rd_idx_i),
    .rd_off_i    (rd_off_i),
    .rd_ack_o    (rd_ack_o),
    .rd_sel_o    (rd_sel),
    .rd_go_o     (rd_go),
    .wr_cl_vld_i (wr_cl_vld_i),
    .wr_cl_we_i  (wr_cl_we_i),
    .wr_cl_idx_i (wr_cl_idx_i),
    .wr_req_i    (wr_req_i),
    .wr_idx_i    (wr_idx_i),
    .wr_off_i    (wr_off_i),
    .wr_ack_o    (wr_ack_o),
    .bank_req_o  (bank_req),
    .bank_we_o   (bank_we),
    .bank_idx_o  (bank_idx),
    .tag_req_o   (tag_req),
    .tag_we_o    (tag_we),
    .tag_idx_o   (tag_idx)
  );

  dcache_arrays u_arrays (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .bank_req_i      (bank_req),
    .bank_we_i       (bank_we),
    .bank_idx_i      (bank_idx),
    .tag_req_i       (tag_req),
    .tag_we_i        (tag_we),
    .tag_idx_i       (tag_idx),
    .wr_cl_vld_i     (wr_cl_vld_i),
    .wr_cl_we_i      (wr_cl_we_i),
    .wr_cl_data_i    (wr_cl_data_i),
    .wr_cl_data_be_i (wr_cl_data_be_i),
    .wr_cl_tag_i     (wr_cl_tag_i),
    .wr_vld_bits_i   (wr_vld_bits_i),
    .wr_req_i        (wr_req_i),
    .wr_data_i       (wr_data_i),
    .wr_data_be_i    (wr_data_be_i),
    .bank_rdata_o    (bank_rdata),
    .tag_rdata_o     (tag_rdata)
  );

  dcache_hit_select u_hit_select (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .rd_go_i       (rd_go),
    .rd_sel_i      (rd_sel),
    .rd_off_i      (rd_off_i),
    .rd_tag_i      (rd_tag_i),
    .bank_rdata_i  (bank_rdata),
    .tag_rdata_i   (tag_rdata),
    .rd_vld_bits_o (rd_vld_bits_o),
    .rd_hit_oh_o   (rd_hit_oh_o),
    .rd_data_o     (rd_data_o)
  );

endmodule

// File: verification/tb_clock_gen.sv
// clock and active-low reset source for the cache memory testbench
`timescale 1ns/1ps

module tb_clock_gen #(
  parameter int unsigned PERIOD_NS    = 8,
  parameter int unsigned RESET_CYCLES = 5
) (
  output logic clk_o,
  output logic rst_no
);

  initial begin : p_clk
    clk_o = 1'b0;
    forever begin
      #(PERIOD_NS / 2.0);
      clk_o = ~clk_o;
    end
  end

  // release just after a rising edge
  initial begin : p_rst
    rst_no = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    #1;
    rst_no = 1'b1;
  end

endmodule

// File: verification/tb_dcache_mem.sv
// testbench of the cache memory block, random traffic checked against a reference model
`timescale 1ns/1ps
`include "dcache_defines.svh"

module tb_dcache_mem import dcache_pkg::*; ();

  localparam int unsigned NP       = `DCACHE_NUM_PORTS;
  localparam int unsigned NW       = `DCACHE_SET_ASSOC;
  localparam int unsigned NS       = `DCACHE_NUM_SETS;
  localparam int unsigned NB       = `DCACHE_NUM_BANKS;
  localparam int unsigned OFF_W    = `DCACHE_OFF_W;
  localparam int unsigned BANK_LSB = OFF_W - $bits(bank_sel_t);
  localparam int unsigned PERIOD   = 8;
  localparam int unsigned RST_CYC  = 5;

  // test lengths in cycles
  localparam int unsigned L_HIT    = 1 + 16 + 16 + 48 + 1;
  localparam int unsigned L_MISS   = 8 + 32 + 1;
  localparam int unsigned L_WRITE  = 32 + 64 + 1;
  localparam int unsigned L_ARB    = 160 + 1;
  localparam int unsigned L_COLL   = 64 + 1;
  localparam int unsigned LIMIT_NS =
    (RST_CYC + 2 + L_HIT + L_MISS + L_WRITE + L_ARB + L_COLL) * PERIOD * 2;

  logic              clk;
  logic              rst_n;
  port_vec_t         rd_req;
  port_vec_t         rd_prio;
  idx_t [NP-1:0]     rd_idx;
  off_t [NP-1:0]     rd_off;
  tag_t [NP-1:0]     rd_tag;
  port_vec_t         rd_ack;
  way_vec_t          rd_vld_bits;
  way_vec_t          rd_hit_oh;
  word_t             rd_data;
  logic              wr_cl_vld;
  way_vec_t          wr_cl_we;
  idx_t              wr_cl_idx;
  tag_t              wr_cl_tag;
  line_t             wr_cl_data;
  line_be_t          wr_cl_data_be;
  way_vec_t          wr_vld_bits;
  way_vec_t          wr_req;
  idx_t              wr_idx;
  off_t              wr_off;
  word_t             wr_data;
  word_be_t          wr_data_be;
  logic              wr_ack;

  // reference model state
  logic              m_valid [NS][NW];
  tag_t              m_tag   [NS][NW];
  word_t             m_data  [NS][NW][NB];
  int unsigned       m_rr;
  tag_t              req_tag [NP];

  // lookup in flight, predicted at grant time
  logic              pend_go;
  int unsigned       pend_port;
  tag_t              pend_tag;
  way_vec_t          pend_hit;
  way_vec_t          pend_vld;
  word_t             pend_data;

  logic [31:0]       lfsr_q;
  string             cur_test;
  int unsigned       n_tests;
  int unsigned       n_checks;
  int unsigned       n_errors;
  int unsigned       test_checks;
  int unsigned       test_errors;

  tb_clock_gen #(.PERIOD_NS(PERIOD), .RESET_CYCLES(RST_CYC)) u_clock_gen (
    .clk_o  (clk),
    .rst_no (rst_n)
  );

  dcache_mem u_dut (
    .clk_i           (clk),
    .rst_ni          (rst_n),
    .rd_req_i        (rd_req),
    .rd_prio_i       (rd_prio),
    .rd_idx_i        (rd_idx),
    .rd_off_i        (rd_off),
    .rd_tag_i        (rd_tag),
    .rd_ack_o        (rd_ack),
    .rd_vld_bits_o   (rd_vld_bits),
    .rd_hit_oh_o     (rd_hit_oh),
    .rd_data_o       (rd_data),
    .wr_cl_vld_i     (wr_cl_vld),
    .wr_cl_we_i      (wr_cl_we),
    .wr_cl_idx_i     (wr_cl_idx),
    .wr_cl_tag_i     (wr_cl_tag),
    .wr_cl_data_i    (wr_cl_data),
    .wr_cl_data_be_i (wr_cl_data_be),
    .wr_vld_bits_i   (wr_vld_bits),
    .wr_req_i        (wr_req),
    .wr_idx_i        (wr_idx),
    .wr_off_i        (wr_off),
    .wr_data_i       (wr_data),
    .wr_data_be_i    (wr_data_be),
    .wr_ack_o        (wr_ack)
  );

  ////////////////////////////////
  // random source and checks
  ////////////////////////////////

  // taps 32, 22, 2, 1
  function automatic logic [31:0] rand_bits(int unsigned n);
    logic [31:0] r;
    r = '0;
    for (int unsigned i = 0; i < n; i++) begin
      lfsr_q = {lfsr_q[30:0], lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0]};
      r = {r[30:0], lfsr_q[0]};
    end
    return r;
  endfunction

  function automatic word_t merge_bytes(word_t old_w, word_t new_w, word_be_t be);
    word_t res;
    res = old_w;
    for (int b = 0; b < $bits(word_be_t); b++) begin
      if (be[b]) begin
        res[8*b +: 8] = new_w[8*b +: 8];
      end
    end
    return res;
  endfunction

  task automatic check_value(string what, logic [63:0] exp, logic [63:0] act);
    test_checks++;
    assert (act === exp) else begin
      $display("error %s: %s expected %h actual %h", cur_test, what, exp, act);
      test_errors++;
    end
  endtask

  task automatic start_test(string name);
    cur_test    = name;
    test_checks = 0;
    test_errors = 0;
  endtask

  task automatic finish_test();
    $display("test %s: %0d checks, %0d errors", cur_test, test_checks, test_errors);
    n_tests++;
    n_checks += test_checks;
    n_errors += test_errors;
  endtask

  ////////////////////////////////
  // reference model
  ////////////////////////////////

  // high class masks low class, then first requester from the pointer upward
  task automatic model_grant(output port_vec_t ack, output int unsigned win, output logic go);
    port_vec_t   cand;
    int unsigned p;
    cand = ((rd_req & rd_prio) != '0) ? (rd_req & rd_prio) : rd_req;
    ack  = '0;
    win  = 0;
    go   = 1'b0;
    for (int unsigned i = 0; i < NP; i++) begin
      p = (m_rr + i) % NP;
      if (!go && cand[p]) begin
        go  = 1'b1;
        win = p;
      end
    end
    if (wr_cl_vld) begin
      go = 1'b0;
    end
    if (go) begin
      ack[win] = 1'b1;
    end
  endtask

  task automatic predict_lookup(idx_t idx, bank_sel_t bank, tag_t tag);
    logic found;
    found     = 1'b0;
    pend_data = m_data[idx][0][bank];
    for (int w = 0; w < NW; w++) begin
      pend_vld[w] = m_valid[idx][w];
      pend_hit[w] = m_valid[idx][w] && (m_tag[idx][w] == tag);
      if (pend_hit[w] && !found) begin
        found     = 1'b1;
        pend_data = m_data[idx][w][bank];
      end
    end
  endtask

  task automatic apply_refill();
    for (int w = 0; w < NW; w++) begin
      if (wr_cl_we[w]) begin
        m_valid[wr_cl_idx][w] = wr_vld_bits[w];
        m_tag[wr_cl_idx][w]   = wr_cl_tag;
        for (int k = 0; k < NB; k++) begin
          m_data[wr_cl_idx][w][k] =
            merge_bytes(m_data[wr_cl_idx][w][k], wr_cl_data[k], wr_cl_data_be[k]);
        end
      end
    end
  endtask

  task automatic apply_word_write(bank_sel_t bank);
    for (int w = 0; w < NW; w++) begin
      if (wr_req[w]) begin
        m_data[wr_idx][w][bank] = merge_bytes(m_data[wr_idx][w][bank], wr_data, wr_data_be);
      end
    end
  endtask

  ////////////////////////////////
  // cycle engine
  ////////////////////////////////

  // entered 1 ns after a rising edge with the inputs already driven
  task automatic run_cycle();
    port_vec_t   exp_ack;
    int unsigned win;
    logic        go;
    logic        exp_wack;
    bank_sel_t   rbank;
    bank_sel_t   wbank;
    for (int p = 0; p < NP; p++) begin
      if (pend_go) begin
        rd_tag[p] = tag_t'(rand_bits(8));
      end else begin
        // last granted tag on every port so that an ungated compare would hit
        rd_tag[p] = pend_tag;
      end
    end
    if (pend_go) begin
      rd_tag[pend_port] = pend_tag;
    end
    #2;
    model_grant(exp_ack, win, go);
    rbank    = rd_off[win][OFF_W-1:BANK_LSB];
    wbank    = wr_off[OFF_W-1:BANK_LSB];
    exp_wack = (wr_req != '0) && !wr_cl_vld && !(go && (rbank == wbank));
    check_value("rd_ack_o", 64'(exp_ack), 64'(rd_ack));
    check_value("wr_ack_o", 64'(exp_wack), 64'(wr_ack));
    if (pend_go) begin
      check_value("rd_hit_oh_o", 64'(pend_hit), 64'(rd_hit_oh));
      check_value("rd_vld_bits_o", 64'(pend_vld), 64'(rd_vld_bits));
      check_value("rd_data_o", 64'(pend_data), 64'(rd_data));
    end else begin
      check_value("rd_hit_oh_o", 64'd0, 64'(rd_hit_oh));
    end
    // the granted read sees the arrays as they are before this edge
    pend_go = go;
    if (go) begin
      pend_port = win;
      pend_tag  = req_tag[win];
      predict_lookup(rd_idx[win], rbank, pend_tag);
      m_rr = (win + 1) % NP;
    end
    if (wr_cl_vld) begin
      apply_refill();
    end
    if (exp_wack) begin
      apply_word_write(wbank);
    end
    @(posedge clk);
    #1;
  endtask

  task automatic idle_inputs();
    rd_req    = '0;
    wr_cl_vld = 1'b0;
    wr_req    = '0;
  endtask

  task automatic drain();
    idle_inputs();
    run_cycle();
  endtask

  task automatic set_refill(idx_t idx, way_vec_t we, tag_t tag, way_vec_t vld, logic full_be);
    wr_cl_vld   = 1'b1;
    wr_cl_we    = we;
    wr_cl_idx   = idx;
    wr_cl_tag   = tag;
    wr_vld_bits = vld;
    for (int k = 0; k < NB; k++) begin
      wr_cl_data[k] = word_t'(rand_bits(32));
    end
    wr_cl_data_be = full_be ? '1 : line_be_t'(rand_bits(16));
  endtask

  task automatic issue_refill(idx_t idx, way_vec_t we, tag_t tag, way_vec_t vld, logic full_be);
    set_refill(idx, we, tag, vld, full_be);
    run_cycle();
    wr_cl_vld = 1'b0;
  endtask

  task automatic set_write(int unsigned way, idx_t idx, off_t off);
    wr_req       = '0;
    wr_req[way]  = 1'b1;
    wr_idx       = idx;
    wr_off       = off;
    wr_data      = word_t'(rand_bits(32));
    wr_data_be   = word_be_t'(rand_bits(4));
  endtask

  // a lone requester without a refill is granted in the same cycle
  task automatic issue_read(int unsigned port, idx_t idx, off_t off, tag_t tag);
    rd_req        = '0;
    rd_req[port]  = 1'b1;
    rd_prio       = port_vec_t'(rand_bits(3));
    rd_idx[port]  = idx;
    rd_off[port]  = off;
    req_tag[port] = tag;
    run_cycle();
    rd_req = '0;
  endtask

  // per-port fields, tags mostly taken from a stored way so that hits occur
  task automatic fill_read_fields();
    for (int p = 0; p < NP; p++) begin
      rd_idx[p]  = idx_t'(rand_bits(4));
      rd_off[p]  = off_t'(rand_bits(4));
      req_tag[p] = m_tag[rd_idx[p]][rand_bits(1)];
    end
    rd_prio = port_vec_t'(rand_bits(3));
  endtask

  ////////////////////////////////
  // tests
  ////////////////////////////////

  task automatic test_hit_read();
    idx_t idx;
    start_test("hit_read");
    drain();
    for (int s = 0; s < NS; s++) begin
      issue_refill(idx_t'(s), '1, tag_t'(rand_bits(8)), '0, 1'b1);
    end
    for (int i = 0; i < 16; i++) begin
      issue_refill(idx_t'(rand_bits(4)), way_vec_t'(1 << rand_bits(1)),
                   tag_t'(rand_bits(8)), '1, 1'b0);
    end
    for (int i = 0; i < 48; i++) begin
      idx = idx_t'(rand_bits(4));
      issue_read(rand_bits(2) % NP, idx, off_t'(rand_bits(4)), m_tag[idx][rand_bits(1)]);
    end
    drain();
    finish_test();
  endtask

  task automatic test_miss_read();
    idx_t dead [8];
    idx_t idx;
    tag_t t;
    start_test("miss_read");
    for (int i = 0; i < 8; i++) begin
      dead[i] = idx_t'(rand_bits(4));
      issue_refill(dead[i], '1, tag_t'(rand_bits(8)), '0, 1'b1);
    end
    for (int i = 0; i < 32; i++) begin
      if (i % 2 == 0) begin
        idx = idx_t'(rand_bits(4));
        t   = tag_t'(rand_bits(8));
        while (t == m_tag[idx][0] || t == m_tag[idx][1]) begin
          t = t + 1'b1;
        end
      end else begin
        idx = dead[rand_bits(3)];
        t   = m_tag[idx][rand_bits(1)];
      end
      issue_read(rand_bits(2) % NP, idx, off_t'(rand_bits(4)), t);
    end
    drain();
    finish_test();
  endtask

  task automatic test_word_write();
    idx_t        idx;
    off_t        off;
    int unsigned way;
    tag_t        t;
    start_test("word_write");
    for (int s = 0; s < NS; s++) begin
      t = tag_t'(rand_bits(8));
      issue_refill(idx_t'(s), 2'b01, t, '1, 1'b1);
      issue_refill(idx_t'(s), 2'b10, t ^ 8'h5a, '1, 1'b1);
    end
    for (int i = 0; i < 32; i++) begin
      idx = idx_t'(rand_bits(4));
      off = off_t'(rand_bits(4));
      way = rand_bits(1);
      set_write(way, idx, off);
      run_cycle();
      wr_req = '0;
      issue_read(rand_bits(2) % NP, idx, off, m_tag[idx][way]);
    end
    drain();
    finish_test();
  endtask

  task automatic test_arbitration();
    start_test("arbitration");
    for (int c = 0; c < 160; c++) begin
      rd_req = port_vec_t'(rand_bits(3));
      fill_read_fields();
      wr_cl_vld = 1'b0;
      wr_req    = '0;
      if (rand_bits(3) == 0) begin
        set_refill(idx_t'(rand_bits(4)), way_vec_t'(rand_bits(2)), tag_t'(rand_bits(8)),
                   way_vec_t'(rand_bits(2)), 1'b0);
      end
      if (rand_bits(2) == 0) begin
        set_write(rand_bits(1), idx_t'(rand_bits(4)), off_t'(rand_bits(4)));
      end
      run_cycle();
    end
    drain();
    finish_test();
  endtask

  // a word write every cycle against a single reader and occasional refills
  task automatic test_write_collision();
    start_test("write_collision");
    for (int c = 0; c < 64; c++) begin
      rd_req = '0;
      if (rand_bits(2) != 0) begin
        rd_req[rand_bits(2) % NP] = 1'b1;
      end
      fill_read_fields();
      wr_cl_vld = 1'b0;
      if (rand_bits(2) == 0) begin
        set_refill(idx_t'(rand_bits(4)), way_vec_t'(rand_bits(2)), tag_t'(rand_bits(8)),
                   '1, 1'b0);
      end
      set_write(rand_bits(1), idx_t'(rand_bits(4)), off_t'(rand_bits(4)));
      run_cycle();
    end
    drain();
    finish_test();
  endtask

  ////////////////////////////////
  // main sequence and watchdog
  ////////////////////////////////

  initial begin : p_main
    lfsr_q        = 32'h3abc_0cbc;
    rd_req        = '0;
    rd_prio       = '0;
    rd_idx        = '0;
    rd_off        = '0;
    rd_tag        = '0;
    wr_cl_vld     = 1'b0;
    wr_cl_we      = '0;
    wr_cl_idx     = '0;
    wr_cl_tag     = '0;
    wr_cl_data    = '0;
    wr_cl_data_be = '0;
    wr_vld_bits   = '0;
    wr_req        = '0;
    wr_idx        = '0;
    wr_off        = '0;
    wr_data       = '0;
    wr_data_be    = '0;
    m_rr          = 0;
    pend_go       = 1'b0;
    pend_port     = 0;
    pend_tag      = '0;
    n_tests       = 0;
    n_checks      = 0;
    n_errors      = 0;
    wait (rst_n === 1'b1);
    @(posedge clk);
    #1;
    test_hit_read();
    test_miss_read();
    test_word_write();
    test_arbitration();
    test_write_collision();
    $display("tests: %0d, checks: %0d, errors: %0d", n_tests, n_checks, n_errors);
    if (n_errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

  initial begin : p_watchdog
    #(LIMIT_NS);
    $display("timeout: the tests did not finish within %0d ns", LIMIT_NS);
    $display("STATUS: FAIL");
    $finish;
  end

endmodule

// File: project.f
+incdir+verilog
verilog/dcache_pkg.sv
verilog/dcache_sram.sv
verilog/dcache_bank_arbiter.sv
verilog/dcache_arrays.sv
verilog/dcache_hit_select.sv
verilog/dcache_mem.sv
verification/tb_clock_gen.sv
verification/tb_dcache_mem.sv

// File: Makefile
TOP := tb_dcache_mem

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --top-module $(TOP) -f project.f

sim:
	verilator --binary --timing -Mdir build --top-module $(TOP) -f project.f
	./build/V$(TOP) > sim.log 2>&1 || true
	cat sim.log
	grep -q "STATUS: PASS" sim.log

clean:
	rm -rf build sim.log
